// File: source/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// memory depths in 32-bit words
`define CPU_IM_WORDS 256
`define CPU_DM_WORDS 256
`define CPU_REGS 32

// host address map, byte addresses
`define CPU_HOST_IM_BASE 32'h0000_0000
`define CPU_HOST_DM_BASE 32'h0000_1000
// write bit 0 = run
`define CPU_HOST_CTRL 32'h0000_2000
// bit 0 running, bit 1 halted
`define CPU_HOST_STATUS 32'h0000_2004
`define CPU_HOST_RETIRED 32'h0000_2008

`endif

// File: source/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

	// ************************************************************
	// instruction word, one per address
	//   [31:26] opcode  [25:21] rd  [20:16] ra  [15:11] rb
	//   [4:0] alu function  [15:0] signed immediate
	//   [25:23] branch condition
	// store writes register rd to memory at ra + imm
	// branch target is pc + 1 + imm, in words
	// ************************************************************

	typedef enum logic [5:0] {
		op_alu    = 6'h01,
		op_addi   = 6'h02,
		op_load   = 6'h03,
		op_store  = 6'h04,
		op_branch = 6'h05,
		op_halt   = 6'h3f
	} opcode_e; // anything else is a no-op

	typedef enum logic [4:0] {
		alu_add = 5'd0,
		alu_sub = 5'd1,
		alu_and = 5'd2,
		alu_or  = 5'd3,
		alu_xor = 5'd4,
		alu_shl = 5'd5,
		alu_shr = 5'd6
	} alu_op_e;

	typedef enum logic [2:0] {
		cond_always = 3'd0,
		cond_eq     = 3'd1,
		cond_ne     = 3'd2,
		cond_lt     = 3'd3,
		cond_ge     = 3'd4,
		cond_cs     = 3'd5,
		cond_cc     = 3'd6,
		cond_never  = 3'd7
	} cond_e;

	typedef enum logic [1:0] {
		wb_alu = 2'd0,
		wb_mem = 2'd1,
		wb_pc  = 2'd2
	} wb_sel_e;

	typedef struct packed {
		logic o;
		logic s;
		logic c;
		logic z;
	} flags_t;

	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm; // second operand from sign extension
		wb_sel_e wb_sel;
		logic    reg_we;
		logic    mem_we;
		logic    flags_we;
		logic    is_branch;
		cond_e   cond;
	} ctrl_t;

	typedef enum logic [2:0] {
		st_idle      = 3'd0,
		st_fetch     = 3'd1,
		st_decode    = 3'd2,
		st_execute   = 3'd3,
		st_memory    = 3'd4,
		st_writeback = 3'd5
	} cu_state_e;

	function automatic logic cond_true(cond_e cond, flags_t f);
		case (cond)
			cond_always: return 1'b1;
			cond_eq:     return f.z;
			cond_ne:     return !f.z;
			cond_lt:     return f.s ^ f.o; // signed less than
			cond_ge:     return !(f.s ^ f.o);
			cond_cs:     return f.c;
			cond_cc:     return !f.c;
			default:     return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: source/cpu_bus_pkg.sv
`default_nettype none

package cpu_bus_pkg;

	typedef enum logic [1:0] {
		axi_okay   = 2'b00,
		axi_slverr = 2'b10
	} axi_resp_e;

	typedef struct packed {
		logic        aw_valid;
		logic [31:0] aw_addr;
		logic        w_valid;
		logic [31:0] w_data;
		logic        b_ready;
		logic        ar_valid;
		logic [31:0] ar_addr;
		logic        r_ready;
	} axil_req_t;

	typedef struct packed {
		logic        aw_ready;
		logic        w_ready;
		logic        b_valid;
		axi_resp_e   b_resp;
		logic        ar_ready;
		logic        r_valid;
		logic [31:0] r_data;
		axi_resp_e   r_resp;
	} axil_rsp_t;

	// host side access to one memory
	typedef struct packed {
		logic        en;
		logic        we;
		logic [7:0]  idx; // word index
		logic [31:0] wdata;
	} host_mem_t;

	typedef enum logic [2:0] {
		hp_idle  = 3'd0,
		hp_wr    = 3'd1,
		hp_wresp = 3'd2,
		hp_rd    = 3'd3,
		hp_rresp = 3'd4
	} hp_state_e;

endpackage

`default_nettype wire

// File: source/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module fetch_stage import cpu_bus_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        pc_we,
	input  logic        ir_we,
	input  logic        start,
	input  logic        take,
	input  logic [31:0] target,
	input  host_mem_t   im_host,
	output logic [31:0] instr,
	output logic [31:0] pc_plus1,
	output logic [31:0] im_rdata
);

	logic [31:0] pc; // word address
	logic [7:0]  im_addr;
	logic [31:0] imem [`CPU_IM_WORDS];

	assign pc_plus1 = pc + 32'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (start) begin
			pc <= '0;
		end else if (pc_we) begin
			pc <= take ? target : pc_plus1;
		end
	end

	// host owns the port only while the core is idle
	assign im_addr = im_host.en ? im_host.idx : pc[7:0];

	always_ff @(posedge clk) begin
		if (im_host.en) begin
			if (im_host.we)
				imem[im_addr] <= im_host.wdata;
			im_rdata <= imem[im_addr];
		end
		if (ir_we)
			instr <= imem[im_addr]; // registered read is the instruction register
	end

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module decode_stage import cpu_isa_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  logic [31:0] instr,
	input  logic [31:0] wb_data,
	input  flags_t      flags,
	output logic [31:0] a,
	output logic [31:0] b,
	output logic [31:0] imm,
	output ctrl_t       ctrl,
	output logic        pc_we,
	output logic        ir_we,
	output logic        stage_en,
	output logic        running,
	output logic        halted,
	output logic        retire
);

	cu_state_e   state;
	cu_state_e   state_nxt;
	opcode_e     opcode;
	logic [4:0]  rd;
	logic [4:0]  ra;
	logic [4:0]  rb_sel;
	ctrl_t       dec;
	logic [31:0] rf [`CPU_REGS];

	assign opcode = opcode_e'(instr[31:26]);
	assign rd = instr[25:21];
	assign ra = instr[20:16];
	assign rb_sel = (opcode == op_store) ? rd : instr[15:11]; // store data sits in rd

	// ************************************************************
	// instruction decode
	// ************************************************************
	always_comb begin
		dec = '0;
		case (opcode)
			op_alu: begin
				dec.alu_op = alu_op_e'(instr[4:0]);
				dec.reg_we = 1'b1;
				dec.flags_we = 1'b1;
			end
			op_addi: begin
				dec.use_imm = 1'b1;
				dec.reg_we = 1'b1;
				dec.flags_we = 1'b1;
			end
			op_load: begin
				dec.use_imm = 1'b1;
				dec.wb_sel = wb_mem;
				dec.reg_we = 1'b1;
			end
			op_store: begin
				dec.use_imm = 1'b1;
				dec.mem_we = 1'b1;
			end
			op_branch: begin
				dec.use_imm = 1'b1;
				dec.is_branch = 1'b1;
				// flags cannot change before execute, so resolve here
				dec.cond = cond_true(cond_e'(instr[25:23]), flags) ? cond_always : cond_never;
			end
			default: ;
		endcase
	end

	// register file and operand latches
	always_ff @(posedge clk) begin
		if (state == st_decode) begin
			a <= (ra == 5'd0) ? '0 : rf[ra];
			b <= (rb_sel == 5'd0) ? '0 : rf[rb_sel];
			imm <= {{16{instr[15]}}, instr[15:0]};
			ctrl <= dec;
		end
		if (state == st_writeback && ctrl.reg_we)
			rf[rd] <= wb_data;
	end

	// ************************************************************
	// control unit
	// ************************************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			halted <= 1'b0;
		end else begin
			state <= state_nxt;
			if (start)
				halted <= 1'b0;
			else if (state == st_decode && opcode == op_halt)
				halted <= 1'b1;
		end
	end

	always_comb begin
		state_nxt = state;
		pc_we = 1'b0;
		retire = 1'b0;
		case (state)
			st_idle: begin
				if (start)
					state_nxt = st_fetch;
			end
			st_fetch: state_nxt = st_decode;
			st_decode: begin
				case (opcode)
					op_halt: begin
						retire = 1'b1;
						state_nxt = st_idle;
					end
					op_alu, op_addi, op_load, op_store, op_branch: state_nxt = st_execute;
					default: begin // no-op
						pc_we = 1'b1;
						retire = 1'b1;
						state_nxt = st_fetch;
					end
				endcase
			end
			st_execute: begin
				if (ctrl.is_branch) begin
					pc_we = 1'b1; // fetch picks target or pc + 1 from take
					retire = 1'b1;
					state_nxt = st_fetch;
				end else if (ctrl.mem_we || ctrl.wb_sel == wb_mem) begin
					state_nxt = st_memory;
				end else begin
					state_nxt = st_writeback;
				end
			end
			st_memory: begin
				if (ctrl.mem_we) begin
					pc_we = 1'b1;
					retire = 1'b1;
					state_nxt = st_fetch;
				end else begin
					state_nxt = st_writeback;
				end
			end
			st_writeback: begin
				pc_we = 1'b1;
				retire = 1'b1;
				state_nxt = st_fetch;
			end
			default: state_nxt = st_idle;
		endcase
	end

	assign ir_we = (state == st_fetch);
	assign stage_en = (state == st_execute);
	assign running = (state != st_idle);

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module execute_stage import cpu_isa_pkg::*, cpu_bus_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        stage_en,
	input  ctrl_t       ctrl,
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [31:0] imm,
	input  logic [31:0] pc_plus1,
	input  host_mem_t   dm_host,
	output logic [31:0] target,
	output logic [31:0] wb_data,
	output logic [31:0] dm_rdata,
	output flags_t      flags,
	output logic        take
);

	logic [31:0] alu_a;
	logic [31:0] alu_b;
	logic [31:0] alu_res;
	logic [32:0] sum;
	flags_t      alu_flags;
	logic [31:0] alu_q;
	logic [31:0] dm_q;
	logic        mem_phase;
	logic [7:0]  dm_addr;
	logic [31:0] dmem [`CPU_DM_WORDS];

	// ************************************************************
	// ALU
	// ************************************************************
	assign alu_a = ctrl.is_branch ? pc_plus1 : a;
	assign alu_b = ctrl.use_imm ? imm : b;

	always_comb begin
		sum = '0;
		alu_res = '0;
		alu_flags = '0;
		case (ctrl.alu_op)
			alu_add: begin
				sum = {1'b0, alu_a} + {1'b0, alu_b};
				alu_res = sum[31:0];
				alu_flags.c = sum[32];
				alu_flags.o = (alu_a[31] == alu_b[31]) && (alu_res[31] != alu_a[31]);
			end
			alu_sub: begin
				sum = {1'b0, alu_a} + {1'b0, ~alu_b} + 33'd1;
				alu_res = sum[31:0];
				alu_flags.c = sum[32]; // set when no borrow
				alu_flags.o = (alu_a[31] != alu_b[31]) && (alu_res[31] != alu_a[31]);
			end
			alu_and: alu_res = alu_a & alu_b;
			alu_or:  alu_res = alu_a | alu_b;
			alu_xor: alu_res = alu_a ^ alu_b;
			alu_shl: alu_res = alu_a << alu_b[4:0];
			alu_shr: alu_res = alu_a >> alu_b[4:0]; // logical
			default: ;
		endcase
		alu_flags.s = alu_res[31];
		alu_flags.z = (alu_res == 32'd0);
	end

	assign target = alu_res;
	assign take = stage_en && ctrl.is_branch && cond_true(ctrl.cond, flags);

	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
			mem_phase <= 1'b0;
		end else begin
			mem_phase <= stage_en; // cycle after execute
			if (stage_en && ctrl.flags_we)
				flags <= alu_flags;
		end
	end

	always_ff @(posedge clk) begin
		if (stage_en)
			alu_q <= alu_res;
	end

	// ************************************************************
	// data memory, address is a + imm held in alu_q
	// ************************************************************
	assign dm_addr = dm_host.en ? dm_host.idx : alu_q[7:0];

	always_ff @(posedge clk) begin
		if (dm_host.en) begin
			if (dm_host.we)
				dmem[dm_addr] <= dm_host.wdata;
			dm_rdata <= dmem[dm_addr];
		end else if (mem_phase) begin
			if (ctrl.mem_we)
				dmem[dm_addr] <= b;
			dm_q <= dmem[dm_addr];
		end
	end

	always_comb begin
		case (ctrl.wb_sel)
			wb_mem:  wb_data = dm_q;
			wb_pc:   wb_data = pc_plus1;
			default: wb_data = alu_q;
		endcase
	end

endmodule

`default_nettype wire

// File: source/host_port.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module host_port import cpu_bus_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  axil_req_t   axil_req,
	input  logic [31:0] im_rdata,
	input  logic [31:0] dm_rdata,
	input  logic        running,
	input  logic        halted,
	input  logic        retire,
	output axil_rsp_t   axil_rsp,
	output host_mem_t   im_host,
	output host_mem_t   dm_host,
	output logic        start
);

	hp_state_e   state;
	logic        wr_go;
	logic        rd_go;
	logic [31:0] addr_q;
	logic [31:0] wdata_q;
	logic [31:0] rdata_q;
	logic [31:0] reg_rdata;
	logic [31:0] retired;
	logic [31:0] im_off;
	logic [31:0] dm_off;
	axi_resp_e   resp_q;
	logic        in_im;
	logic        in_dm;
	logic        is_ctrl;
	logic        is_status;
	logic        is_retired;
	logic        access_ok;
	logic        mem_en;

	// one transaction at a time, writes win a tie
	assign wr_go = (state == hp_idle) && axil_req.aw_valid && axil_req.w_valid;
	assign rd_go = (state == hp_idle) && axil_req.ar_valid && !wr_go;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= hp_idle;
		end else begin
			case (state)
				hp_idle: begin
					if (wr_go)
						state <= hp_wr;
					else if (rd_go)
						state <= hp_rd;
				end
				hp_wr: state <= hp_wresp;
				hp_rd: state <= hp_rresp;
				hp_wresp: begin
					if (axil_req.b_ready)
						state <= hp_idle;
				end
				hp_rresp: begin
					if (axil_req.r_ready)
						state <= hp_idle;
				end
				default: state <= hp_idle;
			endcase
		end
	end

	// ************************************************************
	// address map
	// ************************************************************
	assign im_off = addr_q - `CPU_HOST_IM_BASE;
	assign dm_off = addr_q - `CPU_HOST_DM_BASE;
	assign in_im = im_off < 32'(`CPU_IM_WORDS * 4);
	assign in_dm = dm_off < 32'(`CPU_DM_WORDS * 4);
	assign is_ctrl = (addr_q == `CPU_HOST_CTRL);
	assign is_status = (addr_q == `CPU_HOST_STATUS);
	assign is_retired = (addr_q == `CPU_HOST_RETIRED);

	// memories are locked while the core runs, status is read only
	always_comb begin
		if (in_im || in_dm)
			access_ok = !running;
		else if (state == hp_rd)
			access_ok = is_ctrl || is_status || is_retired;
		else
			access_ok = is_ctrl;
	end

	always_comb begin
		reg_rdata = '0;
		if (is_status)
			reg_rdata = {30'd0, halted, running};
		else if (is_retired)
			reg_rdata = retired;
		else if (is_ctrl)
			reg_rdata = {31'd0, running};
	end

	always_ff @(posedge clk) begin
		if (wr_go) begin
			addr_q <= axil_req.aw_addr;
			wdata_q <= axil_req.w_data;
		end else if (rd_go) begin
			addr_q <= axil_req.ar_addr;
		end
		if (state == hp_wr || state == hp_rd)
			resp_q <= access_ok ? axi_okay : axi_slverr;
		if (state == hp_rd)
			rdata_q <= reg_rdata;
	end

	assign mem_en = (state == hp_wr || state == hp_rd) && !running;

	always_comb begin
		im_host.en = mem_en && in_im;
		im_host.we = (state == hp_wr);
		im_host.idx = im_off[9:2];
		im_host.wdata = wdata_q;
		dm_host.en = mem_en && in_dm;
		dm_host.we = (state == hp_wr);
		dm_host.idx = dm_off[9:2];
		dm_host.wdata = wdata_q;
	end

	assign start = (state == hp_wr) && is_ctrl && wdata_q[0] && !running;

	always_ff @(posedge clk) begin
		if (reset)
			retired <= '0;
		else if (start)
			retired <= '0;
		else if (retire)
			retired <= retired + 32'd1;
	end

	always_comb begin
		axil_rsp.aw_ready = wr_go;
		axil_rsp.w_ready = wr_go;
		axil_rsp.b_valid = (state == hp_wresp);
		axil_rsp.b_resp = resp_q;
		axil_rsp.ar_ready = rd_go;
		axil_rsp.r_valid = (state == hp_rresp);
		axil_rsp.r_resp = resp_q;
		if (in_im)
			axil_rsp.r_data = im_rdata;
		else if (in_dm)
			axil_rsp.r_data = dm_rdata;
		else
			axil_rsp.r_data = rdata_q;
	end

endmodule

`default_nettype wire

// File: source/processor.sv
`timescale 1ns/1ns
`default_nettype none

module processor import cpu_isa_pkg::*, cpu_bus_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp
);

	logic [31:0] instr;
	logic [31:0] pc_plus1;
	logic [31:0] im_rdata;
	logic [31:0] dm_rdata;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm;
	logic [31:0] target;
	logic [31:0] wb_data;
	ctrl_t       ctrl;
	flags_t      flags;
	host_mem_t   im_host;
	host_mem_t   dm_host;
	logic        pc_we;
	logic        ir_we;
	logic        stage_en;
	logic        running;
	logic        halted;
	logic        retire;
	logic        take;
	logic        start;

	fetch_stage fetch (
		.clk(clk),
		.reset(reset),
		.pc_we(pc_we),
		.ir_we(ir_we),
		.start(start),
		.take(take),
		.target(target),
		.im_host(im_host),
		.instr(instr),
		.pc_plus1(pc_plus1),
		.im_rdata(im_rdata)
	);

	decode_stage decode (
		.clk(clk),
		.reset(reset),
		.start(start),
		.instr(instr),
		.wb_data(wb_data),
		.flags(flags),
		.a(a),
		.b(b),
		.imm(imm),
		.ctrl(ctrl),
		.pc_we(pc_we),
		.ir_we(ir_we),
		.stage_en(stage_en),
		.running(running),
		.halted(halted),
		.retire(retire)
	);

	execute_stage execute (
		.clk(clk),
		.reset(reset),
		.stage_en(stage_en),
		.ctrl(ctrl),
		.a(a),
		.b(b),
		.imm(imm),
		.pc_plus1(pc_plus1),
		.dm_host(dm_host),
		.target(target),
		.wb_data(wb_data),
		.dm_rdata(dm_rdata),
		.flags(flags),
		.take(take)
	);

	host_port host (
		.clk(clk),
		.reset(reset),
		.axil_req(axil_req),
		.im_rdata(im_rdata),
		.dm_rdata(dm_rdata),
		.running(running),
		.halted(halted),
		.retire(retire),
		.axil_rsp(axil_rsp),
		.im_host(im_host),
		.dm_host(dm_host),
		.start(start)
	);

endmodule

`default_nettype wire

// File: verif/processor_assert.sv
`timescale 1ns/1ns
`default_nettype none

module processor_assert import cpu_isa_pkg::*, cpu_bus_pkg::*; (
	input logic      clk,
	input logic      reset,
	input cu_state_e state,
	input logic      pc_we,
	input logic      reg_we,
	input logic      running,
	input logic      halted,
	input axil_req_t axil_req,
	input axil_rsp_t axil_rsp
);

	// ************************************************************
	// control unit
	// ************************************************************
	pc_we_state: assert property (@(posedge clk) disable iff (reset)
		pc_we |-> state inside {st_decode, st_execute, st_memory, st_writeback})
		else $error("pc_we outside a retiring state");

	wb_needs_reg_we: assert property (@(posedge clk) disable iff (reset)
		state == st_writeback |-> reg_we)
		else $error("writeback state without a register write");

	run_halt_excl: assert property (@(posedge clk) disable iff (reset)
		!(running && halted))
		else $error("running and halted both high");

	// ************************************************************
	// AXI4-Lite handshakes
	// ************************************************************
	aw_stable: assert property (@(posedge clk) disable iff (reset)
		axil_req.aw_valid && !axil_rsp.aw_ready |=>
			axil_req.aw_valid && $stable(axil_req.aw_addr))
		else $error("aw dropped before ready");

	ar_stable: assert property (@(posedge clk) disable iff (reset)
		axil_req.ar_valid && !axil_rsp.ar_ready |=>
			axil_req.ar_valid && $stable(axil_req.ar_addr))
		else $error("ar dropped before ready");

	b_hold: assert property (@(posedge clk) disable iff (reset)
		axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid)
		else $error("b response dropped before ready");

endmodule

bind decode_stage processor_assert cu_chk (
	.clk(clk),
	.reset(reset),
	.state(state),
	.pc_we(pc_we),
	.reg_we(ctrl.reg_we),
	.running(running),
	.halted(halted),
	.axil_req('0),
	.axil_rsp('0)
);

bind host_port processor_assert host_chk (
	.clk(clk),
	.reset(reset),
	.state(cpu_isa_pkg::st_idle),
	.pc_we(1'b0),
	.reg_we(1'b0),
	.running(running),
	.halted(halted),
	.axil_req(axil_req),
	.axil_rsp(axil_rsp)
);

`default_nettype wire

// File: verif/processor_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module processor_tb import cpu_isa_pkg::*, cpu_bus_pkg::*; ();

	localparam int N_PROGS = 11;
	localparam int WATCHDOG_CYCLES =
		N_PROGS * (`CPU_IM_WORDS * 5 + (`CPU_IM_WORDS + `CPU_DM_WORDS) * 6) + 10000;

	logic        clk;
	logic        reset;
	axil_req_t   axil_req;
	axil_rsp_t   axil_rsp;
	logic [31:0] seed;
	logic [31:0] prog [$];
	logic [31:0] m_im [`CPU_IM_WORDS];
	logic [31:0] m_dm [`CPU_DM_WORDS];
	logic [31:0] m_rf [`CPU_REGS];
	flags_t      m_flags;
	logic [31:0] m_retired;

	processor uut (
		.clk(clk),
		.reset(reset),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp)
	);

	always #50 clk = ~clk;

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired, the DUT stopped responding");
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	function automatic logic [31:0] lcg();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		return (lcg() >> 12) % n;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			$display("Simulation FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	// ************************************************************
	// AXI4-Lite host
	// ************************************************************
	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		logic        hs;
		int unsigned stall;
		stall = rand_below(3);
		@(negedge clk);
		axil_req.aw_valid = 1'b1;
		axil_req.aw_addr = addr;
		axil_req.w_valid = 1'b1;
		axil_req.w_data = data;
		hs = 1'b0;
		while (!hs) begin
			@(posedge clk);
			hs = axil_rsp.aw_ready && axil_rsp.w_ready;
		end
		@(negedge clk);
		axil_req.aw_valid = 1'b0;
		axil_req.w_valid = 1'b0;
		axil_req.b_ready = 1'b0; // back-pressure on the write response
		do @(posedge clk); while (!axil_rsp.b_valid);
		repeat (stall) @(posedge clk);
		@(negedge clk);
		axil_req.b_ready = 1'b1;
		@(posedge clk);
		resp = axil_rsp.b_resp;
	endtask

	task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		logic hs;
		@(negedge clk);
		axil_req.ar_valid = 1'b1;
		axil_req.ar_addr = addr;
		hs = 1'b0;
		while (!hs) begin
			@(posedge clk);
			hs = axil_rsp.ar_ready;
		end
		@(negedge clk);
		axil_req.ar_valid = 1'b0;
		do @(posedge clk); while (!axil_rsp.r_valid);
		data = axil_rsp.r_data;
		resp = axil_rsp.r_resp;
	endtask

	task automatic write_ok(input logic [31:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		check($sformatf("write resp @%h", addr), 32'd0, {30'd0, resp});
	endtask

	task automatic read_ok(input logic [31:0] addr, output logic [31:0] data);
		logic [1:0] resp;
		axi_read(addr, data, resp);
		check($sformatf("read resp @%h", addr), 32'd0, {30'd0, resp});
	endtask

	// ************************************************************
	// instruction encoding and reference model
	// ************************************************************
	function automatic logic [31:0] enc_alu(input logic [4:0] rd, input logic [4:0] ra,
			input logic [4:0] rb, input logic [4:0] fn);
		return {op_alu, rd, ra, rb, 6'd0, fn};
	endfunction

	function automatic logic [31:0] enc_imm(input opcode_e op, input logic [4:0] rd,
			input logic [4:0] ra, input logic [15:0] imm);
		return {op, rd, ra, imm};
	endfunction

	function automatic logic [31:0] enc_branch(input logic [2:0] cond, input logic [15:0] imm);
		return {op_branch, cond, 7'd0, imm};
	endfunction

	function automatic logic [31:0] rf_rd(input logic [4:0] idx);
		return (idx == 5'd0) ? 32'd0 : m_rf[idx];
	endfunction

	function automatic logic cond_model(input logic [2:0] c, input flags_t f);
		case (c)
			3'd0: return 1'b1;
			3'd1: return f.z;
			3'd2: return !f.z;
			3'd3: return f.s != f.o;
			3'd4: return f.s == f.o;
			3'd5: return f.c;
			3'd6: return !f.c;
			default: return 1'b0;
		endcase
	endfunction

	task automatic alu_model(input logic [31:0] x, input logic [31:0] y,
			input logic [4:0] fn, input logic [4:0] rd);
		logic [32:0] wide;
		logic [31:0] res;
		flags_t      f;
		f = '0;
		res = '0;
		case (fn)
			5'd0: begin
				wide = {1'b0, x} + {1'b0, y};
				res = wide[31:0];
				f.c = wide[32];
				f.o = (x[31] == y[31]) && (res[31] != x[31]);
			end
			5'd1: begin
				res = x - y;
				f.c = (x >= y); // no borrow
				f.o = (x[31] != y[31]) && (res[31] != x[31]);
			end
			5'd2: res = x & y;
			5'd3: res = x | y;
			5'd4: res = x ^ y;
			5'd5: res = x << y[4:0];
			5'd6: res = x >> y[4:0];
			default: res = '0;
		endcase
		f.s = res[31];
		f.z = (res == 32'd0);
		m_flags = f;
		if (rd != 5'd0)
			m_rf[rd] = res;
	endtask

	task automatic model_run();
		logic [31:0] pc;
		logic [31:0] w;
		logic [31:0] x;
		logic [31:0] sx;
		logic [31:0] addr;
		logic        done;
		pc = '0;
		done = 1'b0;
		m_retired = '0;
		while (!done) begin
			w = m_im[pc[7:0]];
			sx = {{16{w[15]}}, w[15:0]};
			x = rf_rd(w[20:16]);
			addr = x + sx;
			m_retired = m_retired + 32'd1;
			pc = pc + 32'd1;
			case (w[31:26])
				op_alu:  alu_model(x, rf_rd(w[15:11]), w[4:0], w[25:21]);
				op_addi: alu_model(x, sx, 5'd0, w[25:21]);
				op_load: begin
					if (w[25:21] != 5'd0)
						m_rf[w[25:21]] = m_dm[addr[7:0]];
				end
				op_store: m_dm[addr[7:0]] = rf_rd(w[25:21]);
				op_branch: begin
					if (cond_model(w[25:23], m_flags))
						pc = pc + sx;
				end
				op_halt: done = 1'b1;
				default: ;
			endcase
			if (m_retired > 32'd100000) begin
				$display("reference model ran away without reaching halt");
				$display("Simulation FAILED");
				$fatal(1, "model");
			end
		end
	endtask

	// ************************************************************
	// program handling
	// ************************************************************
	task automatic load_and_start();
		foreach (prog[i]) begin
			write_ok(`CPU_HOST_IM_BASE + 32'(i * 4), prog[i]);
			m_im[i] = prog[i];
		end
		model_run();
		write_ok(`CPU_HOST_CTRL, 32'd1);
	endtask

	task automatic finish_and_verify(input string name);
		logic [31:0] data;
		do read_ok(`CPU_HOST_STATUS, data); while (!data[1]);
		check({name, " status"}, 32'h2, data);
		read_ok(`CPU_HOST_RETIRED, data);
		check({name, " retired"}, m_retired, data);
		for (int i = 0; i < `CPU_DM_WORDS; i++) begin
			read_ok(`CPU_HOST_DM_BASE + 32'(i * 4), data);
			check($sformatf("%s dm[%0d]", name, i), m_dm[i], data);
		end
	endtask

	task automatic push_random_alu();
		if (lcg() & 32'h100)
			prog.push_back(enc_alu(5'(rand_below(32)), 5'(rand_below(32)),
				5'(rand_below(32)), 5'(rand_below(7))));
		else
			prog.push_back(enc_imm(op_addi, 5'(rand_below(32)), 5'(rand_below(32)),
				16'(lcg() >> 16)));
	endtask

	initial begin
		logic [31:0] data;
		logic [31:0] word;
		logic [1:0]  resp;
		logic [15:0] v1;
		clk = 1'b0;
		reset = 1'b1;
		seed = 32'ha946;
		axil_req = '0;
		axil_req.b_ready = 1'b1;
		axil_req.r_ready = 1'b1;
		m_flags = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// host memory access
		for (int i = 0; i < `CPU_IM_WORDS; i++) begin
			word = lcg();
			write_ok(`CPU_HOST_IM_BASE + 32'(i * 4), word);
			m_im[i] = word;
			word = lcg();
			write_ok(`CPU_HOST_DM_BASE + 32'(i * 4), word);
			m_dm[i] = word;
		end
		for (int i = 0; i < `CPU_IM_WORDS; i++) begin
			read_ok(`CPU_HOST_IM_BASE + 32'(i * 4), data);
			check($sformatf("host im[%0d]", i), m_im[i], data);
			read_ok(`CPU_HOST_DM_BASE + 32'(i * 4), data);
			check($sformatf("host dm[%0d]", i), m_dm[i], data);
		end

		// random ALU programs, every register stored at the end
		for (int p = 0; p < 4; p++) begin
			prog.delete();
			for (int r = 1; r < 32; r++)
				prog.push_back(enc_imm(op_addi, 5'(r), 5'd0, 16'(lcg() >> 16)));
			repeat (40) push_random_alu();
			for (int r = 1; r < 32; r++)
				prog.push_back(enc_imm(op_store, 5'(r), 5'd0, 16'(128 + r)));
			prog.push_back({op_halt, 26'd0});
			load_and_start();
			finish_and_verify($sformatf("alu prog %0d", p));
		end

		// loads, mixing and stores at random addresses
		for (int p = 0; p < 4; p++) begin
			prog.delete();
			repeat (8)
				prog.push_back(enc_imm(op_load, 5'(1 + rand_below(31)), 5'(rand_below(32)),
					16'(rand_below(256))));
			repeat (16) push_random_alu();
			repeat (12)
				prog.push_back(enc_imm(op_store, 5'(rand_below(32)), 5'(rand_below(32)),
					16'(rand_below(256))));
			prog.push_back({op_halt, 26'd0});
			load_and_start();
			finish_and_verify($sformatf("ldst prog %0d", p));
		end

		// each condition after a compare, r7 shows the path taken
		for (int p = 0; p < 2; p++) begin
			prog.delete();
			for (int t = 0; t < 32; t++) begin
				v1 = 16'(lcg() >> 16);
				prog.push_back(enc_imm(op_addi, 5'd7, 5'd0, 16'd0));
				prog.push_back(enc_imm(op_addi, 5'd1, 5'd0, v1));
				prog.push_back(enc_imm(op_addi, 5'd2, 5'd0,
					(rand_below(4) == 0) ? v1 : 16'(lcg() >> 16)));
				prog.push_back(enc_alu(5'd3, 5'd1, 5'd2, 5'(rand_below(2))));
				prog.push_back(enc_branch(3'(t % 8), 16'd1));
				prog.push_back(enc_imm(op_addi, 5'd7, 5'd0, 16'(t + 1)));
				prog.push_back(enc_imm(op_store, 5'd7, 5'd0, 16'(64 + t)));
			end
			prog.push_back({op_halt, 26'd0});
			load_and_start();
			finish_and_verify($sformatf("branch prog %0d", p));
		end

		// countdown loop keeps the core busy while the host pokes memory
		prog.delete();
		prog.push_back(enc_imm(op_addi, 5'd9, 5'd0, 16'd100));
		prog.push_back(enc_imm(op_addi, 5'd9, 5'd9, 16'hffff));
		prog.push_back(enc_branch(3'd2, 16'hfffe));
		prog.push_back(enc_imm(op_store, 5'd9, 5'd0, 16'd200));
		prog.push_back({op_halt, 26'd0});
		load_and_start();
		axi_write(`CPU_HOST_DM_BASE + 32'd20, lcg(), resp);
		check("dm write while running", 32'd2, {30'd0, resp});
		axi_read(`CPU_HOST_IM_BASE, data, resp);
		check("im read while running", 32'd2, {30'd0, resp});
		read_ok(`CPU_HOST_STATUS, data);
		check("status while running", 32'h1, data);
		finish_and_verify("busy prog");

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: processor.f
+incdir+source
source/cpu_isa_pkg.sv
source/cpu_bus_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/host_port.sv
source/processor.sv
verif/processor_assert.sv
verif/processor_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module processor_tb \
	-f processor.f -o sim_processor

./obj_dir/sim_processor | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
	exit 0
else
	exit 1
fi
